/* design/icache_pkg.sv */
package icache_pkg;

  // fetch and memory bus widths
  localparam int ADDR_W  = 32;
  localparam int FETCH_W = 64;
  localparam int MEM_W   = 32;

  // address split, tag | index | offset
  localparam int OFFSET_W = 6;
  localparam int INDEX_W  = 7;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // line geometry
  // 128 lines of 64 bytes, 8 KB total
  localparam int NUM_LINES = 1 << INDEX_W;

  // 64 byte line over a 32 bit bus
  localparam int BEATS_PER_LINE = (1 << OFFSET_W) / (MEM_W / 8);
  localparam int BEAT_CNT_W     = $clog2(BEATS_PER_LINE);

  // split view of one fetch address
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } fetch_fields_t;

  // one address word, read either flat or as fields
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    fetch_fields_t     f;
  } fetch_addr_u;

endpackage

/* design/icache_tag_array.sv */
`timescale 1ns/100ps

module icache_tag_array
  import icache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // registered fetch address from the controller
  input  fetch_addr_u lookup_addr_i,
  // pulse after the last refill beat
  input  logic        tag_we_i,
  output logic        hit_o
);

  // one valid bit per line, cleared by reset
  logic [NUM_LINES-1:0] valid_q;

  // tag storage
  logic [TAG_W-1:0] tag_mem [NUM_LINES];

  logic [INDEX_W-1:0] idx;
  logic [TAG_W-1:0]   tag;

  assign idx = lookup_addr_i.f.index;
  assign tag = lookup_addr_i.f.tag;

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_we_i) begin
      valid_q[idx] <= 1'b1;
    end
  end

  // tag store
  // written once the whole line is in the data array
  always_ff @(posedge clk) begin
    if (tag_we_i) begin
      tag_mem[idx] <= tag;
    end
  end

  // combinational compare on the registered address
  // the controller only looks at this in lookup
  assign hit_o = valid_q[idx] && (tag_mem[idx] == tag);

endmodule

/* design/icache_data_array.sv */
`timescale 1ns/100ps

module icache_data_array
  import icache_pkg::*;
(
  input  logic                  clk,
  // live fetch index, read one cycle ahead
  input  logic [INDEX_W-1:0]    rd_index_i,
  // registered offset, picks the doubleword
  input  logic [OFFSET_W-1:0]   rd_offset_i,
  // refill side, one 32 bit word per beat
  input  logic [BEAT_CNT_W-1:0] fill_beat_i,
  input  logic                  fill_we_i,
  input  logic [MEM_W-1:0]      fill_data_i,
  input  logic [INDEX_W-1:0]    fill_index_i,
  output logic [FETCH_W-1:0]    line_rdata_o
);

  localparam int LINE_W    = BEATS_PER_LINE * MEM_W;
  localparam int DW_PER_LN = LINE_W / FETCH_W;
  localparam int DW_SEL_W  = $clog2(DW_PER_LN);

  // word 0 of a line sits in the low bits
  logic [LINE_W-1:0] line_mem [NUM_LINES];

  // registered line, words kept in pairs
  logic [FETCH_W-1:0] pair_q [DW_PER_LN];

  // offset bits 5..3 name the doubleword
  logic [DW_SEL_W-1:0] dw_sel;

  assign dw_sel = rd_offset_i[OFFSET_W-1 -: DW_SEL_W];

  // one beat per cycle into the line being refilled
  always_ff @(posedge clk) begin
    if (fill_we_i) begin
      line_mem[fill_index_i][fill_beat_i*MEM_W +: MEM_W] <= fill_data_i;
    end
  end

  // synchronous read
  // index is sampled in idle, data is used in lookup
  always_ff @(posedge clk) begin
    for (int i = 0; i < DW_PER_LN; i++) begin
      pair_q[i] <= line_mem[rd_index_i][i*FETCH_W +: FETCH_W];
    end
  end

  // lower word address in the low half
  assign line_rdata_o = pair_q[dw_sel];

endmodule

/* design/icache_ctrl.sv */
`timescale 1ns/100ps

module icache_ctrl
  import icache_pkg::*;
#(
  parameter logic [ADDR_W-1:0] CACHED_BASE = 32'h8000_0000,
  parameter logic [ADDR_W-1:0] CACHED_SIZE = 32'h1000_0000
) (
  input  logic                  clk,
  input  logic                  rst,
  // fetch stage
  input  logic                  fetch_req_i,
  input  fetch_addr_u           fetch_addr_i,
  output logic                  fetch_valid_o,
  output logic [FETCH_W-1:0]    fetch_data_o,
  // memory read port
  output logic [ADDR_W-1:0]     mem_araddr_o,
  output logic [7:0]            mem_arlen_o,
  output logic                  mem_arvalid_o,
  input  logic                  mem_rvalid_i,
  input  logic [MEM_W-1:0]      mem_rdata_i,
  // tag array
  output fetch_addr_u           lookup_addr_o,
  output logic                  tag_we_o,
  input  logic                  hit_i,
  // data array
  output logic [INDEX_W-1:0]    rd_index_o,
  output logic [OFFSET_W-1:0]   rd_offset_o,
  output logic [BEAT_CNT_W-1:0] fill_beat_o,
  output logic                  fill_we_o,
  output logic [MEM_W-1:0]      fill_data_o,
  input  logic [FETCH_W-1:0]    line_rdata_i
);

  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_LOOKUP   = 2'd1;
  localparam logic [1:0] ST_REFILL   = 2'd2;
  localparam logic [1:0] ST_UNCACHED = 2'd3;

  localparam logic [BEAT_CNT_W-1:0] LAST_BEAT = BEAT_CNT_W'(BEATS_PER_LINE - 1);

  logic [1:0]            state_q;
  fetch_addr_u           addr_q;
  logic [BEAT_CNT_W-1:0] beat_cnt_q;
  logic                  arvalid_q;
  logic [ADDR_W-1:0]     araddr_q;
  logic [7:0]            arlen_q;
  logic                  tag_we_q;
  logic                  unc_ready_q;
  logic [FETCH_W-1:0]    unc_word_q;

  logic cached;
  logic beat;
  logic lookup_hit;

  // window check, wraps cleanly for any base
  assign cached = (addr_q.flat - CACHED_BASE) < CACHED_SIZE;

  // one beat per cycle with both valids high
  assign beat = arvalid_q && mem_rvalid_i;

  assign lookup_hit = (state_q == ST_LOOKUP) && cached && hit_i;

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ST_IDLE;
      beat_cnt_q  <= '0;
      arvalid_q   <= 1'b0;
      tag_we_q    <= 1'b0;
      unc_ready_q <= 1'b0;
    end else begin
      // tag write is a single cycle pulse
      tag_we_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (fetch_req_i) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (lookup_hit) begin
            state_q <= ST_IDLE;
          end else if (cached) begin
            // line miss, burst from the line base
            state_q    <= ST_REFILL;
            arvalid_q  <= 1'b1;
            beat_cnt_q <= '0;
          end else begin
            state_q   <= ST_UNCACHED;
            arvalid_q <= 1'b1;
          end
        end
        ST_REFILL: begin
          if (beat) begin
            if (beat_cnt_q == LAST_BEAT) begin
              // line complete, mark valid and look up again
              arvalid_q <= 1'b0;
              tag_we_q  <= 1'b1;
              state_q   <= ST_IDLE;
            end else begin
              beat_cnt_q <= beat_cnt_q + 1'b1;
            end
          end
        end
        default: begin
          // uncached read, holds one extra cycle for the response
          if (unc_ready_q) begin
            unc_ready_q <= 1'b0;
            state_q     <= ST_IDLE;
          end else if (beat) begin
            arvalid_q   <= 1'b0;
            unc_ready_q <= 1'b1;
          end
        end
      endcase
    end
  end

  // address and request payload
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE) begin
      addr_q <= fetch_addr_i;
    end
    if (state_q == ST_LOOKUP) begin
      if (cached) begin
        araddr_q <= {addr_q.f.tag, addr_q.f.index, {OFFSET_W{1'b0}}};
        arlen_q  <= 8'(BEATS_PER_LINE - 1);
      end else begin
        araddr_q <= addr_q.flat;
        arlen_q  <= 8'd0;
      end
    end
  end

  // uncached word placed by the low offset bits
  always_ff @(posedge clk) begin
    if ((state_q == ST_UNCACHED) && beat) begin
      case (addr_q.f.offset[2:0])
        3'b000:  unc_word_q <= {32'b0, mem_rdata_i};
        3'b010:  unc_word_q <= {16'b0, mem_rdata_i, 16'b0};
        3'b100:  unc_word_q <= {mem_rdata_i, 32'b0};
        default: unc_word_q <= '0;
      endcase
    end
  end

  assign mem_araddr_o  = araddr_q;
  assign mem_arlen_o   = arlen_q;
  assign mem_arvalid_o = arvalid_q;

  assign lookup_addr_o = addr_q;
  assign tag_we_o      = tag_we_q;

  // read address runs one cycle ahead of the lookup
  assign rd_index_o  = fetch_addr_i.f.index;
  assign rd_offset_o = addr_q.f.offset;

  assign fill_beat_o = beat_cnt_q;
  assign fill_we_o   = (state_q == ST_REFILL) && beat;
  assign fill_data_o = mem_rdata_i;

  // result
  assign fetch_valid_o = lookup_hit || unc_ready_q;
  assign fetch_data_o  = cached ? line_rdata_i : unc_word_q;

endmodule

/* design/icache_top.sv */
`timescale 1ns/100ps

module icache_top
  import icache_pkg::*;
#(
  parameter logic [ADDR_W-1:0] CACHED_BASE = 32'h8000_0000,
  parameter logic [ADDR_W-1:0] CACHED_SIZE = 32'h1000_0000
) (
  input  logic               clk,
  input  logic               rst,
  // fetch stage
  input  logic               fetch_req_i,
  input  fetch_addr_u        fetch_addr_i,
  output logic               fetch_valid_o,
  output logic [FETCH_W-1:0] fetch_data_o,
  // memory read port
  output logic [ADDR_W-1:0]  mem_araddr_o,
  output logic [7:0]         mem_arlen_o,
  output logic               mem_arvalid_o,
  input  logic               mem_rvalid_i,
  input  logic [MEM_W-1:0]   mem_rdata_i
);

  // controller to tag array
  fetch_addr_u lookup_addr;
  logic        tag_we;
  logic        hit;

  // controller to data array
  logic [INDEX_W-1:0]    rd_index;
  logic [OFFSET_W-1:0]   rd_offset;
  logic [BEAT_CNT_W-1:0] fill_beat;
  logic                  fill_we;
  logic [MEM_W-1:0]      fill_data;
  logic [FETCH_W-1:0]    line_rdata;

  icache_ctrl #(
    .CACHED_BASE (CACHED_BASE),
    .CACHED_SIZE (CACHED_SIZE)
  ) u_icache_ctrl (
    .clk           (clk),
    .rst           (rst),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_data_o  (fetch_data_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arlen_o   (mem_arlen_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .lookup_addr_o (lookup_addr),
    .tag_we_o      (tag_we),
    .hit_i         (hit),
    .rd_index_o    (rd_index),
    .rd_offset_o   (rd_offset),
    .fill_beat_o   (fill_beat),
    .fill_we_o     (fill_we),
    .fill_data_o   (fill_data),
    .line_rdata_i  (line_rdata)
  );

  icache_tag_array u_icache_tag_array (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (lookup_addr),
    .tag_we_i      (tag_we),
    .hit_o         (hit)
  );

  // refill goes to the line held in the controller's address register
  icache_data_array u_icache_data_array (
    .clk          (clk),
    .rd_index_i   (rd_index),
    .rd_offset_i  (rd_offset),
    .fill_beat_i  (fill_beat),
    .fill_we_i    (fill_we),
    .fill_data_i  (fill_data),
    .fill_index_i (lookup_addr.f.index),
    .line_rdata_o (line_rdata)
  );

endmodule

/* test/icache_mem_model.sv */
`timescale 1ns/100ps

module icache_mem_model
  import icache_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  // read request from the cache
  input  logic [ADDR_W-1:0] mem_araddr_i,
  input  logic [7:0]        mem_arlen_i,
  input  logic              mem_arvalid_i,
  output logic              mem_rvalid_o,
  output logic [MEM_W-1:0]  mem_rdata_o,
  // chance in percent that a cycle carries no beat
  input  int                stall_pct_i,
  // request log for the testbench
  output int                req_count_o,
  output logic [ADDR_W-1:0] req_addr_o,
  output logic [7:0]        req_len_o
);

  // request in progress, arvalid seen at the last falling edge
  logic busy;
  // beats already taken in this request
  int   beats;

  // memory contents, a pure function of the word address
  function automatic logic [MEM_W-1:0] word_at(input logic [ADDR_W-1:0] addr);
    logic [31:0] wa;
    wa = {2'b00, addr[31:2]};
    return (wa * 32'h9e37_79b1) ^ 32'h3c5a_96e1;
  endfunction

  initial begin
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
    req_count_o  = 0;
    req_addr_o   = '0;
    req_len_o    = '0;
    busy         = 1'b0;
    beats        = 0;
    forever begin
      @(negedge clk);
      // beat went across at the last rising edge
      if (busy && mem_rvalid_o) begin
        beats++;
      end
      if (rst || !mem_arvalid_i) begin
        busy         = 1'b0;
        mem_rvalid_o = 1'b0;
      end else begin
        // new request, log address and length
        if (!busy) begin
          busy        = 1'b1;
          beats       = 0;
          req_addr_o  = mem_araddr_i;
          req_len_o   = mem_arlen_i;
          req_count_o = req_count_o + 1;
        end
        // all beats given, wait for arvalid to drop
        if (beats > int'(req_len_o)) begin
          mem_rvalid_o = 1'b0;
        end else if (int'($urandom % 100) < stall_pct_i) begin
          // stall, data held
          mem_rvalid_o = 1'b0;
        end else begin
          mem_rvalid_o = 1'b1;
          // ascending words from the request address
          mem_rdata_o  = word_at(req_addr_o + 32'(beats * 4));
        end
      end
    end
  end

endmodule

/* test/tb_icache_top.sv */
`timescale 1ns/100ps

module tb_icache_top
  import icache_pkg::*;
();

  localparam int                CLK_PERIOD      = 4;
  localparam int                RESET_CYCLES    = 10;
  localparam logic [31:0]       SEED            = 32'hfe89b8a8;
  localparam logic [ADDR_W-1:0] CACHED_BASE     = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] CACHED_SIZE     = 32'h1000_0000;
  localparam int                STALL_PCT       = 30;
  localparam int                HEAVY_STALL_PCT = 75;
  localparam int                NUM_RANDOM      = 400;
  // directed fetches plus the random mix
  localparam int                NUM_FETCHES     = 36 + NUM_RANDOM;
  // a refill at heavy stalls averages 64 cycles
  // budget per fetch leaves a wide margin
  localparam int                FETCH_BUDGET    = 300;

  logic               clk = 1'b0;
  logic               rst;
  logic               fetch_req;
  fetch_addr_u        fetch_addr;
  logic               fetch_valid;
  logic [FETCH_W-1:0] fetch_data;
  logic [ADDR_W-1:0]  mem_araddr;
  logic [7:0]         mem_arlen;
  logic               mem_arvalid;
  logic               mem_rvalid;
  logic [MEM_W-1:0]   mem_rdata;
  int                 stall_pct;
  int                 req_count;
  logic [ADDR_W-1:0]  req_addr;
  logic [7:0]         req_len;

  // reference model with a valid bit and tag per line
  logic               valid_m [NUM_LINES];
  logic [TAG_W-1:0]   tag_m [NUM_LINES];

  int errors;
  int checks;
  int tests;
  int tests_failed;
  int err_mark;

  // request stability monitor
  logic               ar_busy;
  logic [ADDR_W-1:0]  ar_addr_held;
  logic [7:0]         ar_len_held;

  always #(CLK_PERIOD / 2) clk = ~clk;

  icache_top #(
    .CACHED_BASE (CACHED_BASE),
    .CACHED_SIZE (CACHED_SIZE)
  ) u_icache_top (
    .clk           (clk),
    .rst           (rst),
    .fetch_req_i   (fetch_req),
    .fetch_addr_i  (fetch_addr),
    .fetch_valid_o (fetch_valid),
    .fetch_data_o  (fetch_data),
    .mem_araddr_o  (mem_araddr),
    .mem_arlen_o   (mem_arlen),
    .mem_arvalid_o (mem_arvalid),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rdata_i   (mem_rdata)
  );

  icache_mem_model u_mem_model (
    .clk           (clk),
    .rst           (rst),
    .mem_araddr_i  (mem_araddr),
    .mem_arlen_i   (mem_arlen),
    .mem_arvalid_i (mem_arvalid),
    .mem_rvalid_o  (mem_rvalid),
    .mem_rdata_o   (mem_rdata),
    .stall_pct_i   (stall_pct),
    .req_count_o   (req_count),
    .req_addr_o    (req_addr),
    .req_len_o     (req_len)
  );

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  function automatic logic in_window(input logic [ADDR_W-1:0] addr);
    return (addr >= CACHED_BASE) && (addr < CACHED_BASE + CACHED_SIZE);
  endfunction

  // same data formula as the memory model
  function automatic logic [MEM_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
    logic [31:0] wa;
    wa = {2'b00, addr[31:2]};
    return (wa * 32'h9e37_79b1) ^ 32'h3c5a_96e1;
  endfunction

  // aligned doubleword with the lower address in the low half
  function automatic logic [63:0] expected_line_dw(input logic [ADDR_W-1:0] addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    return {expected_word(base + 32'd4), expected_word(base)};
  endfunction

  // single uncached word placed by offset bits 2..0
  function automatic logic [63:0] placed_word(input logic [ADDR_W-1:0] addr);
    logic [31:0] w;
    w = expected_word(addr);
    case (addr[2:0])
      3'd0:    return {32'd0, w};
      3'd2:    return {16'd0, w, 16'd0};
      3'd4:    return {w, 32'd0};
      default: return 64'd0;
    endcase
  endfunction

  // a few lines in and out of the window
  // some of them share an index
  function automatic logic [ADDR_W-1:0] random_addr();
    logic [31:0]        r;
    logic [INDEX_W-1:0] idx;
    fetch_addr_u        a;
    r = $urandom;
    if (r[31:30] == 2'b00) begin
      a.flat = 32'h0000_7000 | {26'd0, r[5:0]};
    end else begin
      idx = (r[11:10] == 2'd2) ? 7'd100 : {5'd0, r[11:10]} + 7'd5;
      a.flat     = CACHED_BASE | {17'd0, r[9:8], 13'd0};
      a.f.index  = idx;
      a.f.offset = r[5:0];
    end
    return a.flat;
  endfunction

  // one full fetch predicted by the model
  // then one idle cycle where fetch_valid_o must be low again
  task automatic run_fetch(input logic [ADDR_W-1:0] addr);
    fetch_addr_u a;
    logic        cached;
    logic        hit;
    int          lat;
    int          reqs;
    logic [63:0] exp_data;
    a.flat   = addr;
    cached   = in_window(addr);
    hit      = cached && valid_m[a.f.index] && (tag_m[a.f.index] == a.f.tag);
    exp_data = cached ? expected_line_dw(addr) : placed_word(addr);
    reqs     = req_count;
    fetch_addr = a;
    fetch_req  = 1'b1;
    lat        = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!fetch_valid);
    fetch_req = 1'b0;
    check("fetch_data_o", fetch_data, exp_data);
    if (hit) begin
      check("hit latency", 64'(lat), 64'd1);
      check("memory requests", 64'(req_count - reqs), 64'd0);
    end else begin
      check("memory requests", 64'(req_count - reqs), 64'd1);
      check("mem_araddr_o", 64'(req_addr), cached ? 64'({addr[31:6], 6'd0}) : 64'(addr));
      check("mem_arlen_o", 64'(req_len), cached ? 64'd15 : 64'd0);
    end
    if (cached) begin
      valid_m[a.f.index] = 1'b1;
      tag_m[a.f.index]   = a.f.tag;
    end
    @(negedge clk);
    check("fetch_valid_o", 64'(fetch_valid), 64'd0);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
    end
  endtask

  // address and length hold while arvalid is high
  always @(negedge clk) begin
    if (rst || !mem_arvalid) begin
      ar_busy = 1'b0;
    end else if (!ar_busy) begin
      ar_busy      = 1'b1;
      ar_addr_held = mem_araddr;
      ar_len_held  = mem_arlen;
    end else begin
      check("mem_araddr_o", 64'(mem_araddr), 64'(ar_addr_held));
      check("mem_arlen_o", 64'(mem_arlen), 64'(ar_len_held));
    end
  end

  initial begin
    #((RESET_CYCLES + NUM_FETCHES * FETCH_BUDGET) * CLK_PERIOD);
    $display("timeout: watchdog expired before all fetches completed");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    rst             = 1'b1;
    fetch_req       = 1'b0;
    fetch_addr.flat = '0;
    stall_pct       = STALL_PCT;
    errors          = 0;
    checks          = 0;
    tests           = 0;
    tests_failed    = 0;
    for (int i = 0; i < NUM_LINES; i++) begin
      valid_m[i] = 1'b0;
      tag_m[i]   = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    err_mark = errors;
    check("fetch_valid_o", 64'(fetch_valid), 64'd0);
    check("mem_arvalid_o", 64'(mem_arvalid), 64'd0);
    end_test("reset");

    // first fetch refills and the repeat hits
    err_mark = errors;
    run_fetch(32'h8000_1234);
    run_fetch(32'h8000_1234);
    end_test("cold miss then hit");

    // same index 41 with tags 8 KB apart
    err_mark = errors;
    for (int i = 0; i < 4; i++) begin
      run_fetch(32'h8000_0a48);
      run_fetch(32'h8000_2a50);
    end
    end_test("conflict eviction");

    // every lane case and both window edges
    err_mark = errors;
    for (int k = 0; k < 8; k++) begin
      run_fetch(32'h0000_4100 + 32'(k));
    end
    run_fetch(32'h7fff_fffc);
    run_fetch(32'h9000_0002);
    end_test("uncached reads");

    err_mark  = errors;
    stall_pct = HEAVY_STALL_PCT;
    for (int i = 0; i < 8; i++) begin
      run_fetch(CACHED_BASE + 32'h0010_0000 + 32'(i * 65));
      run_fetch(32'h0000_6000 + 32'(i * 6));
    end
    stall_pct = STALL_PCT;
    end_test("back-pressure");

    err_mark = errors;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      run_fetch(random_addr());
    end
    end_test("random mix");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* verilog.f */
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_ctrl.sv
design/icache_top.sv
test/icache_mem_model.sv
test/tb_icache_top.sv

/* Makefile */
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

PASS_MSG := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
